//--- common/hwpe_params.svh
// Bus widths and counts for the HWPE subsystem; include before using any HWPE_* macro
`ifndef HWPE_PARAMS_SVH
`define HWPE_PARAMS_SVH

// Data and address widths, addresses count words
`define HWPE_DW 32
`define HWPE_AW 16

// Configuration transaction id
`define HWPE_ID_W 4

// Cores that receive the done event
`define HWPE_N_CORES 4

// Engines behind the shared ports, and the select that picks one
`define HWPE_N_ENG 2
`define HWPE_SEL_W 1

// Job length in words
`define HWPE_LEN_W 8

`endif

//--- common/hwpe_pkg.sv
// Shared types of the HWPE subsystem; modules import it with hwpe_pkg::* in their header
`include "hwpe_params.svh"

package hwpe_pkg;

  //////////////////////////////
  // Engine kinds
  //////////////////////////////

  // Value equals the select that addresses the engine
  typedef enum logic [`HWPE_SEL_W-1:0] {
    ENG_COPY = 1'b0,
    ENG_SUM  = 1'b1
  } hwpe_kind_e;

  // Phases common to both engines
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD_REQ,
    ST_RD_WAIT,
    ST_WR_REQ,
    ST_DONE
  } eng_state_e;

  //////////////////////////////
  // Register map
  //////////////////////////////

  // Index from config address bits 3:2
  // REG_CMD triggers on write and reads back status
  typedef enum logic [1:0] {
    REG_SRC,
    REG_DST,
    REG_LEN,
    REG_CMD
  } reg_idx_e;

endpackage

//--- hw/hwpe_cfg_demux.sv
// Config target demux; steers each request to the selected engine and returns its response
`include "hwpe_params.svh"

module hwpe_cfg_demux (
  input  logic                                     clk,
  input  logic                                     rst_i,
  input  logic [`HWPE_SEL_W-1:0]                   sel_i,
  // Outside target side
  input  logic                                     cfg_req_i,
  output logic                                     cfg_gnt_o,
  output logic                                     cfg_r_valid_o,
  output logic [`HWPE_DW-1:0]                      cfg_r_rdata_o,
  output logic [`HWPE_ID_W-1:0]                    cfg_r_id_o,
  // Per-engine register blocks
  output logic [`HWPE_N_ENG-1:0]                   eng_req_o,
  input  logic [`HWPE_N_ENG-1:0]                   eng_gnt_i,
  input  logic [`HWPE_N_ENG-1:0]                   eng_r_valid_i,
  input  logic [`HWPE_N_ENG-1:0][`HWPE_DW-1:0]     eng_r_rdata_i,
  input  logic [`HWPE_N_ENG-1:0][`HWPE_ID_W-1:0]   eng_r_id_i
);

  logic [`HWPE_N_ENG-1:0] sel_dec;
  logic [`HWPE_SEL_W-1:0] rsp_sel_q;

  always_comb begin
    sel_dec        = '0;
    sel_dec[sel_i] = 1'b1;
  end

  assign eng_req_o = sel_dec & {`HWPE_N_ENG{cfg_req_i}};
  assign cfg_gnt_o = eng_gnt_i[sel_i];

  // Remember who took the request, the response comes one cycle later
  always_ff @(posedge clk) begin
    if (rst_i) begin
      rsp_sel_q <= '0;
    end else if (cfg_req_i && cfg_gnt_o) begin
      rsp_sel_q <= sel_i;
    end
  end

  assign cfg_r_valid_o = eng_r_valid_i[rsp_sel_q];
  assign cfg_r_rdata_o = eng_r_rdata_i[rsp_sel_q];
  assign cfg_r_id_o    = eng_r_id_i[rsp_sel_q];

  // Only one register block may answer at a time
  a_one_rsp: assert property (@(posedge clk) disable iff (rst_i) $onehot0(eng_r_valid_i))
    else $error("several engines answered at once: %b", eng_r_valid_i);

endmodule

//--- hw/hwpe_ctrl_regs.sv
// Job registers of one engine on the config bus; source, destination, length and command
`include "hwpe_params.svh"

module hwpe_ctrl_regs
  import hwpe_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_i,
  // Config target
  input  logic                     req_i,
  input  logic [`HWPE_AW-1:0]      add_i,
  input  logic                     wen_i,
  input  logic [`HWPE_DW/8-1:0]    be_i,
  input  logic [`HWPE_DW-1:0]      wdata_i,
  input  logic [`HWPE_ID_W-1:0]    id_i,
  output logic                     gnt_o,
  output logic                     r_valid_o,
  output logic [`HWPE_DW-1:0]      r_rdata_o,
  output logic [`HWPE_ID_W-1:0]    r_id_o,
  // Engine side
  input  logic                     busy_i,
  output logic                     start_o,
  output logic [`HWPE_AW-1:0]      src_o,
  output logic [`HWPE_AW-1:0]      dst_o,
  output logic [`HWPE_LEN_W-1:0]   len_o
);

  reg_idx_e                idx;
  logic                    wr_en;
  logic [`HWPE_DW-1:0]     be_mask;
  logic [`HWPE_DW-1:0]     src_ext;
  logic [`HWPE_DW-1:0]     dst_ext;
  logic [`HWPE_DW-1:0]     len_ext;
  logic [`HWPE_DW-1:0]     rd_val;

  // Keep the bytes not enabled and take the others from the bus
  function automatic logic [`HWPE_DW-1:0] merge_be(input logic [`HWPE_DW-1:0] old_val,
                                                   input logic [`HWPE_DW-1:0] new_val,
                                                   input logic [`HWPE_DW-1:0] mask);
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  assign idx     = reg_idx_e'(add_i[3:2]);
  assign gnt_o   = req_i;
  assign wr_en   = req_i && !wen_i && !busy_i;
  assign start_o = wr_en && (idx == REG_CMD);

  always_comb begin
    for (int b = 0; b < `HWPE_DW/8; b++) begin
      be_mask[8*b +: 8] = {8{be_i[b]}};
    end
  end

  assign src_ext = {{(`HWPE_DW-`HWPE_AW){1'b0}}, src_o};
  assign dst_ext = {{(`HWPE_DW-`HWPE_AW){1'b0}}, dst_o};
  assign len_ext = {{(`HWPE_DW-`HWPE_LEN_W){1'b0}}, len_o};

  always_ff @(posedge clk) begin
    if (rst_i) begin
      src_o <= '0;
      dst_o <= '0;
      len_o <= '0;
    end else if (wr_en) begin
      case (idx)
        REG_SRC: src_o <= `HWPE_AW'(merge_be(src_ext, wdata_i, be_mask));
        REG_DST: dst_o <= `HWPE_AW'(merge_be(dst_ext, wdata_i, be_mask));
        REG_LEN: len_o <= `HWPE_LEN_W'(merge_be(len_ext, wdata_i, be_mask));
        default: ;
      endcase
    end
  end

  // Status word carries busy in bit 0
  always_comb begin
    case (idx)
      REG_SRC: rd_val = src_ext;
      REG_DST: rd_val = dst_ext;
      REG_LEN: rd_val = len_ext;
      default: rd_val = {{(`HWPE_DW-1){1'b0}}, busy_i};
    endcase
  end

  //////////////////////////////
  // Response one cycle later
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      r_valid_o <= 1'b0;
    end else begin
      r_valid_o <= req_i;
    end
  end

  always_ff @(posedge clk) begin
    if (req_i) begin
      r_id_o <= id_i;
    end
    if (req_i && wen_i) begin
      r_rdata_o <= rd_val;
    end
  end

endmodule

//--- hw/copy_engine/copy_engine.sv
// Block-copy engine; for each word reads source plus k and writes it to destination plus k
`include "hwpe_params.svh"

module copy_engine
  import hwpe_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic                       en_i,
  // Job
  input  logic                       start_i,
  input  logic [`HWPE_AW-1:0]        src_i,
  input  logic [`HWPE_AW-1:0]        dst_i,
  input  logic [`HWPE_LEN_W-1:0]     len_i,
  // Memory initiator
  output logic                       mem_req_o,
  output logic [`HWPE_AW-1:0]        mem_add_o,
  output logic                       mem_wen_o,
  output logic [`HWPE_DW-1:0]        mem_wdata_o,
  input  logic                       mem_gnt_i,
  input  logic                       mem_r_valid_i,
  input  logic [`HWPE_DW-1:0]        mem_r_data_i,
  // Status
  output logic                       busy_o,
  output logic [`HWPE_N_CORES-1:0]   evt_o
);

  eng_state_e               state_q;
  logic [`HWPE_AW-1:0]      src_q;
  logic [`HWPE_AW-1:0]      dst_q;
  logic [`HWPE_AW-1:0]      offs;
  logic [`HWPE_LEN_W-1:0]   len_q;
  logic [`HWPE_LEN_W-1:0]   cnt_q;
  logic [`HWPE_DW-1:0]      data_q;
  logic                     last_word;

  assign offs      = {{(`HWPE_AW-`HWPE_LEN_W){1'b0}}, cnt_q};
  assign last_word = (cnt_q + 1'b1) == len_q;

  //////////////////////////////
  // FSM, frozen while disabled
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else if (en_i) begin
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            cnt_q   <= '0;
            state_q <= (len_i == '0) ? ST_DONE : ST_RD_REQ;
          end
        end
        ST_RD_REQ: begin
          if (mem_gnt_i) state_q <= ST_RD_WAIT;
        end
        ST_RD_WAIT: begin
          if (mem_r_valid_i) state_q <= ST_WR_REQ;
        end
        ST_WR_REQ: begin
          if (mem_gnt_i) begin
            cnt_q   <= cnt_q + 1'b1;
            state_q <= last_word ? ST_DONE : ST_RD_REQ;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Job capture and the word in flight
  always_ff @(posedge clk) begin
    if (en_i && state_q == ST_IDLE && start_i) begin
      src_q <= src_i;
      dst_q <= dst_i;
      len_q <= len_i;
    end
    if (en_i && state_q == ST_RD_WAIT && mem_r_valid_i) begin
      data_q <= mem_r_data_i;
    end
  end

  assign mem_req_o   = en_i && (state_q == ST_RD_REQ || state_q == ST_WR_REQ);
  assign mem_wen_o   = (state_q == ST_RD_REQ);
  assign mem_add_o   = mem_wen_o ? src_q + offs : dst_q + offs;
  assign mem_wdata_o = data_q;

  assign busy_o = state_q inside {ST_RD_REQ, ST_RD_WAIT, ST_WR_REQ};
  assign evt_o  = {`HWPE_N_CORES{en_i && state_q == ST_DONE}};

  // A waiting request keeps its address and write data
  a_req_stable: assert property (@(posedge clk) disable iff (rst_i)
    mem_req_o && !mem_gnt_i ##1 en_i |->
      mem_req_o && $stable(mem_add_o) && $stable(mem_wen_o) &&
      (mem_wen_o || $stable(mem_wdata_o)))
    else $error("copy engine changed a pending memory request");

endmodule

//--- hw/sum_engine/sum_engine.sv
// Block-sum engine; reads the source words, adds them modulo 2^32 and writes the total
`include "hwpe_params.svh"

module sum_engine
  import hwpe_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic                       en_i,
  // Job
  input  logic                       start_i,
  input  logic [`HWPE_AW-1:0]        src_i,
  input  logic [`HWPE_AW-1:0]        dst_i,
  input  logic [`HWPE_LEN_W-1:0]     len_i,
  // Memory initiator
  output logic                       mem_req_o,
  output logic [`HWPE_AW-1:0]        mem_add_o,
  output logic                       mem_wen_o,
  output logic [`HWPE_DW-1:0]        mem_wdata_o,
  input  logic                       mem_gnt_i,
  input  logic                       mem_r_valid_i,
  input  logic [`HWPE_DW-1:0]        mem_r_data_i,
  // Status
  output logic                       busy_o,
  output logic [`HWPE_N_CORES-1:0]   evt_o
);

  eng_state_e               state_q;
  logic [`HWPE_AW-1:0]      src_q;
  logic [`HWPE_AW-1:0]      dst_q;
  logic [`HWPE_LEN_W-1:0]   len_q;
  logic [`HWPE_LEN_W-1:0]   cnt_q;
  logic [`HWPE_DW-1:0]      acc_q;
  logic                     last_word;

  assign last_word = (cnt_q + 1'b1) == len_q;

  //////////////////////////////
  // FSM, frozen while disabled
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else if (en_i) begin
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            cnt_q   <= '0;
            // Empty job still writes a zero total
            state_q <= (len_i == '0) ? ST_WR_REQ : ST_RD_REQ;
          end
        end
        ST_RD_REQ: begin
          if (mem_gnt_i) state_q <= ST_RD_WAIT;
        end
        ST_RD_WAIT: begin
          if (mem_r_valid_i) begin
            cnt_q   <= cnt_q + 1'b1;
            state_q <= last_word ? ST_WR_REQ : ST_RD_REQ;
          end
        end
        ST_WR_REQ: begin
          if (mem_gnt_i) state_q <= ST_DONE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Job capture and running total
  always_ff @(posedge clk) begin
    if (en_i && state_q == ST_IDLE && start_i) begin
      src_q <= src_i;
      dst_q <= dst_i;
      len_q <= len_i;
      acc_q <= '0;
    end else if (en_i && state_q == ST_RD_WAIT && mem_r_valid_i) begin
      acc_q <= acc_q + mem_r_data_i;
    end
  end

  assign mem_req_o   = en_i && (state_q == ST_RD_REQ || state_q == ST_WR_REQ);
  assign mem_wen_o   = (state_q == ST_RD_REQ);
  assign mem_add_o   = mem_wen_o ? src_q + {{(`HWPE_AW-`HWPE_LEN_W){1'b0}}, cnt_q} : dst_q;
  assign mem_wdata_o = acc_q;

  assign busy_o = state_q inside {ST_RD_REQ, ST_RD_WAIT, ST_WR_REQ};
  assign evt_o  = {`HWPE_N_CORES{en_i && state_q == ST_DONE}};

  // A waiting request keeps its address and write data
  a_req_stable: assert property (@(posedge clk) disable iff (rst_i)
    mem_req_o && !mem_gnt_i ##1 en_i |->
      mem_req_o && $stable(mem_add_o) && $stable(mem_wen_o) &&
      (mem_wen_o || $stable(mem_wdata_o)))
    else $error("sum engine changed a pending memory request");

endmodule

//--- hw/hwpe_mem_mux.sv
// Static memory port mux; forwards the selected engine and routes its busy flag and events
`include "hwpe_params.svh"

module hwpe_mem_mux
  import hwpe_pkg::*;
(
  input  logic                                      clk,
  input  logic [`HWPE_SEL_W-1:0]                    sel_i,
  // Engine side
  input  logic [`HWPE_N_ENG-1:0]                    eng_req_i,
  input  logic [`HWPE_N_ENG-1:0][`HWPE_AW-1:0]      eng_add_i,
  input  logic [`HWPE_N_ENG-1:0]                    eng_wen_i,
  input  logic [`HWPE_N_ENG-1:0][`HWPE_DW-1:0]      eng_wdata_i,
  output logic [`HWPE_N_ENG-1:0]                    eng_gnt_o,
  output logic [`HWPE_N_ENG-1:0]                    eng_r_valid_o,
  // Outside memory port
  output logic                                      mem_req_o,
  output logic [`HWPE_AW-1:0]                       mem_add_o,
  output logic                                      mem_wen_o,
  output logic [`HWPE_DW-1:0]                       mem_wdata_o,
  input  logic                                      mem_gnt_i,
  input  logic                                      mem_r_valid_i,
  // Status
  input  logic [`HWPE_N_ENG-1:0]                    busy_i,
  input  logic [`HWPE_N_ENG-1:0][`HWPE_N_CORES-1:0] evt_i,
  output logic                                      busy_o,
  output logic [`HWPE_N_CORES-1:0]                  evt_o
);

  hwpe_kind_e sel_kind;

  assign sel_kind = hwpe_kind_e'(sel_i);

  assign mem_req_o   = eng_req_i[sel_kind];
  assign mem_add_o   = eng_add_i[sel_kind];
  assign mem_wen_o   = eng_wen_i[sel_kind];
  assign mem_wdata_o = eng_wdata_i[sel_kind];

  // Unselected engines never see a grant or read data strobe
  always_comb begin
    eng_gnt_o               = '0;
    eng_r_valid_o           = '0;
    eng_gnt_o[sel_kind]     = mem_gnt_i;
    eng_r_valid_o[sel_kind] = mem_r_valid_i;
  end

  assign busy_o = busy_i[sel_kind];
  assign evt_o  = evt_i[sel_kind];

  a_gnt_needs_req: assert property (@(posedge clk) mem_gnt_i |-> mem_req_o)
    else $error("memory grant without request, engine %s", sel_kind.name());

endmodule

//--- hw/hwpe_subsystem.sv
// HWPE subsystem top; copy and sum engines behind one config target and one memory port
`include "hwpe_params.svh"

module hwpe_subsystem
  import hwpe_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic                       hwpe_en_i,
  input  logic [`HWPE_SEL_W-1:0]     hwpe_sel_i,
  // Configuration target
  input  logic                       cfg_req_i,
  input  logic [`HWPE_AW-1:0]        cfg_add_i,
  input  logic                       cfg_wen_i,
  input  logic [`HWPE_DW/8-1:0]      cfg_be_i,
  input  logic [`HWPE_DW-1:0]        cfg_wdata_i,
  input  logic [`HWPE_ID_W-1:0]      cfg_id_i,
  output logic                       cfg_gnt_o,
  output logic                       cfg_r_valid_o,
  output logic [`HWPE_DW-1:0]        cfg_r_rdata_o,
  output logic [`HWPE_ID_W-1:0]      cfg_r_id_o,
  // Memory initiator
  output logic                       mem_req_o,
  output logic [`HWPE_AW-1:0]        mem_add_o,
  output logic                       mem_wen_o,
  output logic [`HWPE_DW-1:0]        mem_wdata_o,
  input  logic                       mem_gnt_i,
  input  logic                       mem_r_valid_i,
  input  logic [`HWPE_DW-1:0]        mem_r_data_i,
  // Status
  output logic                       busy_o,
  output logic [`HWPE_N_CORES-1:0]   evt_o
);

  logic [`HWPE_N_ENG-1:0]                      eng_en;
  logic [`HWPE_N_ENG-1:0]                      reg_req;
  logic [`HWPE_N_ENG-1:0]                      reg_gnt;
  logic [`HWPE_N_ENG-1:0]                      reg_r_valid;
  logic [`HWPE_N_ENG-1:0][`HWPE_DW-1:0]        reg_r_rdata;
  logic [`HWPE_N_ENG-1:0][`HWPE_ID_W-1:0]      reg_r_id;
  logic [`HWPE_N_ENG-1:0]                      job_start;
  logic [`HWPE_N_ENG-1:0][`HWPE_AW-1:0]        job_src;
  logic [`HWPE_N_ENG-1:0][`HWPE_AW-1:0]        job_dst;
  logic [`HWPE_N_ENG-1:0][`HWPE_LEN_W-1:0]     job_len;
  logic [`HWPE_N_ENG-1:0]                      m_req;
  logic [`HWPE_N_ENG-1:0][`HWPE_AW-1:0]        m_add;
  logic [`HWPE_N_ENG-1:0]                      m_wen;
  logic [`HWPE_N_ENG-1:0][`HWPE_DW-1:0]        m_wdata;
  logic [`HWPE_N_ENG-1:0]                      m_gnt;
  logic [`HWPE_N_ENG-1:0]                      m_r_valid;
  logic [`HWPE_N_ENG-1:0]                      busy;
  logic [`HWPE_N_ENG-1:0][`HWPE_N_CORES-1:0]   evt;

  //////////////////////////////
  // Config side
  //////////////////////////////

  hwpe_cfg_demux i_cfg_demux (
    .clk           ( clk           ),
    .rst_i         ( rst_i         ),
    .sel_i         ( hwpe_sel_i    ),
    .cfg_req_i     ( cfg_req_i     ),
    .cfg_gnt_o     ( cfg_gnt_o     ),
    .cfg_r_valid_o ( cfg_r_valid_o ),
    .cfg_r_rdata_o ( cfg_r_rdata_o ),
    .cfg_r_id_o    ( cfg_r_id_o    ),
    .eng_req_o     ( reg_req       ),
    .eng_gnt_i     ( reg_gnt       ),
    .eng_r_valid_i ( reg_r_valid   ),
    .eng_r_rdata_i ( reg_r_rdata   ),
    .eng_r_id_i    ( reg_r_id      )
  );

  for (genvar i = 0; i < `HWPE_N_ENG; i++) begin : gen_eng
    localparam hwpe_kind_e eng_kind = hwpe_kind_e'(i);

    // Engine advances only while enabled and selected
    assign eng_en[i] = hwpe_en_i && (hwpe_sel_i == eng_kind);

    // Registers run on the free clock so config works while disabled
    hwpe_ctrl_regs i_regs (
      .clk       ( clk            ),
      .rst_i     ( rst_i          ),
      .req_i     ( reg_req[i]     ),
      .add_i     ( cfg_add_i      ),
      .wen_i     ( cfg_wen_i      ),
      .be_i      ( cfg_be_i       ),
      .wdata_i   ( cfg_wdata_i    ),
      .id_i      ( cfg_id_i       ),
      .gnt_o     ( reg_gnt[i]     ),
      .r_valid_o ( reg_r_valid[i] ),
      .r_rdata_o ( reg_r_rdata[i] ),
      .r_id_o    ( reg_r_id[i]    ),
      .busy_i    ( busy[i]        ),
      .start_o   ( job_start[i]   ),
      .src_o     ( job_src[i]     ),
      .dst_o     ( job_dst[i]     ),
      .len_o     ( job_len[i]     )
    );

    if (eng_kind == ENG_COPY) begin : gen_copy
      copy_engine i_copy (
        .clk ( clk ), .rst_i ( rst_i ), .en_i ( eng_en[i] ),
        .start_i       ( job_start[i] ),
        .src_i         ( job_src[i]   ),
        .dst_i         ( job_dst[i]   ),
        .len_i         ( job_len[i]   ),
        .mem_req_o     ( m_req[i]     ),
        .mem_add_o     ( m_add[i]     ),
        .mem_wen_o     ( m_wen[i]     ),
        .mem_wdata_o   ( m_wdata[i]   ),
        .mem_gnt_i     ( m_gnt[i]     ),
        .mem_r_valid_i ( m_r_valid[i] ),
        .mem_r_data_i  ( mem_r_data_i ),
        .busy_o        ( busy[i]      ),
        .evt_o         ( evt[i]       )
      );
    end else begin : gen_sum
      sum_engine i_sum (
        .clk ( clk ), .rst_i ( rst_i ), .en_i ( eng_en[i] ),
        .start_i       ( job_start[i] ),
        .src_i         ( job_src[i]   ),
        .dst_i         ( job_dst[i]   ),
        .len_i         ( job_len[i]   ),
        .mem_req_o     ( m_req[i]     ),
        .mem_add_o     ( m_add[i]     ),
        .mem_wen_o     ( m_wen[i]     ),
        .mem_wdata_o   ( m_wdata[i]   ),
        .mem_gnt_i     ( m_gnt[i]     ),
        .mem_r_valid_i ( m_r_valid[i] ),
        .mem_r_data_i  ( mem_r_data_i ),
        .busy_o        ( busy[i]      ),
        .evt_o         ( evt[i]       )
      );
    end
  end

  //////////////////////////////
  // Memory side
  //////////////////////////////

  hwpe_mem_mux i_mem_mux (
    .clk           ( clk           ),
    .sel_i         ( hwpe_sel_i    ),
    .eng_req_i     ( m_req         ),
    .eng_add_i     ( m_add         ),
    .eng_wen_i     ( m_wen         ),
    .eng_wdata_i   ( m_wdata       ),
    .eng_gnt_o     ( m_gnt         ),
    .eng_r_valid_o ( m_r_valid     ),
    .mem_req_o     ( mem_req_o     ),
    .mem_add_o     ( mem_add_o     ),
    .mem_wen_o     ( mem_wen_o     ),
    .mem_wdata_o   ( mem_wdata_o   ),
    .mem_gnt_i     ( mem_gnt_i     ),
    .mem_r_valid_i ( mem_r_valid_i ),
    .busy_i        ( busy          ),
    .evt_i         ( evt           ),
    .busy_o        ( busy_o        ),
    .evt_o         ( evt_o         )
  );

endmodule

//--- dv/hwpe_mem_model.sv
// Testbench word memory for the HWPE memory port; random grant delay, reads return a cycle later
`include "hwpe_params.svh"

module hwpe_mem_model (
  input  logic                 clk,
  input  logic                 rst_i,
  input  logic                 req_i,
  input  logic [`HWPE_AW-1:0]  add_i,
  input  logic                 wen_i,
  input  logic [`HWPE_DW-1:0]  wdata_i,
  output logic                 gnt_o,
  output logic                 r_valid_o,
  output logic [`HWPE_DW-1:0]  r_data_o,
  output logic                 err_o
);

  // Full 64K word space, loaded by the testbench
  logic [`HWPE_DW-1:0] mem [0:(1<<`HWPE_AW)-1];

  logic [1:0]           delay_q;
  logic                 pend_q;
  logic [`HWPE_AW-1:0]  add_q;
  logic                 wen_q;
  logic [`HWPE_DW-1:0]  wdata_q;

  // Grant once the wait count has run out
  assign gnt_o = req_i && (delay_q == 2'd0);

  always @(posedge clk) begin
    if (rst_i) begin
      delay_q   <= 2'd0;
      r_valid_o <= 1'b0;
      pend_q    <= 1'b0;
      err_o     <= 1'b0;
    end else begin
      r_valid_o <= req_i && gnt_o && wen_i;
      if (req_i && gnt_o) begin
        delay_q <= 2'($urandom_range(3, 0));
        if (wen_i) begin
          r_data_o <= mem[add_i];
        end else begin
          mem[add_i] <= wdata_i;
        end
      end else if (req_i) begin
        delay_q <= delay_q - 2'd1;
      end
      // A waiting request must hold its address, direction and data
      if (pend_q && req_i) begin
        assert (add_i == add_q && wen_i == wen_q && (wen_i || wdata_i == wdata_q)) else begin
          $display("Memory request changed at time %0t before it was granted", $time);
          err_o <= 1'b1;
        end
      end
      pend_q  <= req_i && !gnt_o;
      add_q   <= add_i;
      wen_q   <= wen_i;
      wdata_q <= wdata_i;
    end
  end

endmodule

//--- dv/hwpe_subsystem_tb.sv
// Testbench top for the HWPE subsystem; random register traffic and copy/sum jobs vs a model
`include "hwpe_params.svh"

module hwpe_subsystem_tb
  import hwpe_pkg::*;
();

  localparam int N_JOBS     = 20;
  localparam int N_RB       = 40;
  localparam int MAX_CYCLES = N_JOBS * 255 * 12 + 2000;

  logic                        clk;
  logic                        rst_i;
  logic                        hwpe_en;
  logic [`HWPE_SEL_W-1:0]      hwpe_sel;
  logic                        cfg_req;
  logic [`HWPE_AW-1:0]         cfg_add;
  logic                        cfg_wen;
  logic [`HWPE_DW/8-1:0]       cfg_be;
  logic [`HWPE_DW-1:0]         cfg_wdata;
  logic [`HWPE_ID_W-1:0]       cfg_id;
  logic                        cfg_gnt;
  logic                        cfg_r_valid;
  logic [`HWPE_DW-1:0]         cfg_r_rdata;
  logic [`HWPE_ID_W-1:0]       cfg_r_id;
  logic                        mem_req;
  logic [`HWPE_AW-1:0]         mem_add;
  logic                        mem_wen;
  logic [`HWPE_DW-1:0]         mem_wdata;
  logic                        mem_gnt;
  logic                        mem_r_valid;
  logic [`HWPE_DW-1:0]         mem_r_data;
  logic                        mem_err;
  logic                        busy;
  logic [`HWPE_N_CORES-1:0]    evt;
  int                          cycles;

  // Reference state
  logic [`HWPE_DW-1:0] shadow_mem [0:(1<<`HWPE_AW)-1];
  logic [`HWPE_DW-1:0] reg_sh [`HWPE_N_ENG][3];

  hwpe_subsystem dut0 (
    .clk           ( clk         ),
    .rst_i         ( rst_i       ),
    .hwpe_en_i     ( hwpe_en     ),
    .hwpe_sel_i    ( hwpe_sel    ),
    .cfg_req_i     ( cfg_req     ),
    .cfg_add_i     ( cfg_add     ),
    .cfg_wen_i     ( cfg_wen     ),
    .cfg_be_i      ( cfg_be      ),
    .cfg_wdata_i   ( cfg_wdata   ),
    .cfg_id_i      ( cfg_id      ),
    .cfg_gnt_o     ( cfg_gnt     ),
    .cfg_r_valid_o ( cfg_r_valid ),
    .cfg_r_rdata_o ( cfg_r_rdata ),
    .cfg_r_id_o    ( cfg_r_id    ),
    .mem_req_o     ( mem_req     ),
    .mem_add_o     ( mem_add     ),
    .mem_wen_o     ( mem_wen     ),
    .mem_wdata_o   ( mem_wdata   ),
    .mem_gnt_i     ( mem_gnt     ),
    .mem_r_valid_i ( mem_r_valid ),
    .mem_r_data_i  ( mem_r_data  ),
    .busy_o        ( busy        ),
    .evt_o         ( evt         )
  );

  hwpe_mem_model mem0 (
    .clk       ( clk         ),
    .rst_i     ( rst_i       ),
    .req_i     ( mem_req     ),
    .add_i     ( mem_add     ),
    .wen_i     ( mem_wen     ),
    .wdata_i   ( mem_wdata   ),
    .gnt_o     ( mem_gnt     ),
    .r_valid_o ( mem_r_valid ),
    .r_data_o  ( mem_r_data  ),
    .err_o     ( mem_err     )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////
  // Watchdogs
  //////////////////////////////

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  end

  always @(negedge clk) begin
    assert (!mem_err) else begin
      $display("The memory model saw a pending request change before its grant");
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  end

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR time %0t %s got %h expected %h", $time, name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  // One config access that returns on the negedge carrying the response
  task automatic cfg_access(input logic [`HWPE_SEL_W-1:0] sel, input reg_idx_e idx,
                            input logic wr, input logic [3:0] be,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    logic [`HWPE_ID_W-1:0] id;
    id = 4'($urandom_range(15, 0));
    @(negedge clk);
    check_eq("cfg_r_valid_o", 32'(cfg_r_valid), 32'd0);
    hwpe_sel  = sel;
    cfg_req   = 1'b1;
    cfg_add   = {12'h000, idx, 2'b00};
    cfg_wen   = !wr;
    cfg_be    = be;
    cfg_wdata = wdata;
    cfg_id    = id;
    @(posedge clk);
    check_eq("cfg_gnt_o", 32'(cfg_gnt), 32'd1);
    @(negedge clk);
    cfg_req = 1'b0;
    check_eq("cfg_r_valid_o", 32'(cfg_r_valid), 32'd1);
    check_eq("cfg_r_id_o", 32'(cfg_r_id), 32'(id));
    rdata = cfg_r_rdata;
  endtask

  function automatic logic [31:0] reg_width_mask(input reg_idx_e idx);
    return (idx == REG_LEN) ? 32'h0000_00ff : 32'h0000_ffff;
  endfunction

  // Byte-enabled write mirrored into the shadow registers
  task automatic reg_write(input int e, input reg_idx_e idx, input logic [3:0] be,
                           input logic [31:0] data);
    logic [31:0] m;
    logic [31:0] rd;
    cfg_access(1'(e), idx, 1'b1, be, data, rd);
    for (int b = 0; b < 4; b++) begin
      m[8*b +: 8] = {8{be[b]}};
    end
    reg_sh[e][idx] = ((reg_sh[e][idx] & ~m) | (data & m)) & reg_width_mask(idx);
  endtask

  task automatic reg_read_check(input int e, input reg_idx_e idx);
    logic [31:0] rd;
    cfg_access(1'(e), idx, 1'b0, 4'hf, 32'h0, rd);
    check_eq("cfg_r_rdata_o", rd, reg_sh[e][idx]);
  endtask

  // Nothing may move on the memory port while the engine is disabled
  task automatic pause_engine(input int e);
    hwpe_en = 1'b0;
    reg_read_check(e, REG_SRC);
    repeat (12) begin
      @(negedge clk);
      check_eq("mem_req_o", 32'(mem_req), 32'd0);
      check_eq("evt_o", 32'(evt), 32'd0);
      check_eq("busy_o", 32'(busy), 32'd1);
    end
    hwpe_en = 1'b1;
  endtask

  //////////////////////////////
  // Jobs
  //////////////////////////////

  task automatic run_job(input int e, input int j);
    logic [15:0] src;
    logic [15:0] dst;
    logic [7:0]  len;
    logic [31:0] acc;
    logic [31:0] rd;
    logic        do_pause;
    src = 16'($urandom);
    dst = 16'($urandom);
    len = 8'($urandom_range(255, 0));
    // The first job of each engine is empty
    if (j < `HWPE_N_ENG) begin
      len = 8'd0;
    end
    reg_write(e, REG_SRC, 4'hf, 32'(src));
    reg_write(e, REG_DST, 4'hf, 32'(dst));
    reg_write(e, REG_LEN, 4'hf, 32'(len));
    // Expected memory word by word in engine order
    if (e == int'(ENG_COPY)) begin
      for (int k = 0; k < int'(len); k++) begin
        shadow_mem[16'(dst + 16'(k))] = shadow_mem[16'(src + 16'(k))];
      end
    end else begin
      acc = 32'h0;
      for (int k = 0; k < int'(len); k++) begin
        acc = acc + shadow_mem[16'(src + 16'(k))];
      end
      shadow_mem[dst] = acc;
    end
    cfg_access(1'(e), REG_CMD, 1'b1, 4'hf, 32'h1, rd);
    if (!(e == int'(ENG_COPY) && len == 8'd0)) begin
      check_eq("busy_o", 32'(busy), 32'd1);
    end
    // Trigger while busy must be ignored
    if (len != 8'd0) begin
      cfg_access(1'(e), REG_CMD, 1'b1, 4'hf, 32'h1, rd);
    end
    do_pause = (j % 3 == 0) && (len >= 8'd4);
    while (evt == '0) begin
      check_eq("busy_o", 32'(busy), 32'd1);
      if (do_pause && mem_req) begin
        pause_engine(e);
        do_pause = 1'b0;
      end
      @(negedge clk);
    end
    check_eq("evt_o", 32'(evt), 32'hf);
    check_eq("busy_o", 32'(busy), 32'd0);
    @(negedge clk);
    check_eq("evt_o", 32'(evt), 32'd0);
    cfg_access(1'(e), REG_CMD, 1'b0, 4'hf, 32'h0, rd);
    check_eq("cfg_r_rdata_o", rd, 32'd0);
    repeat (4) begin
      @(negedge clk);
      check_eq("busy_o", 32'(busy), 32'd0);
      check_eq("evt_o", 32'(evt), 32'd0);
    end
    for (int a = 0; a < (1 << `HWPE_AW); a++) begin
      check_eq($sformatf("mem[%h]", a), mem0.mem[a], shadow_mem[a]);
    end
  endtask

  initial begin
    int          e;
    reg_idx_e    idx;
    void'($urandom(32'h4b15));
    cycles    = 0;
    rst_i     = 1'b1;
    hwpe_en   = 1'b1;
    hwpe_sel  = '0;
    cfg_req   = 1'b0;
    cfg_add   = '0;
    cfg_wen   = 1'b1;
    cfg_be    = '0;
    cfg_wdata = '0;
    cfg_id    = '0;
    for (int i = 0; i < `HWPE_N_ENG; i++) begin
      for (int r = 0; r < 3; r++) begin
        reg_sh[i][r] = 32'h0;
      end
    end
    for (int a = 0; a < (1 << `HWPE_AW); a++) begin
      shadow_mem[a] = $urandom;
      mem0.mem[a]   = shadow_mem[a];
    end
    repeat (10) @(negedge clk);
    check_eq("cfg_r_valid_o", 32'(cfg_r_valid), 32'd0);
    check_eq("mem_req_o", 32'(mem_req), 32'd0);
    check_eq("busy_o", 32'(busy), 32'd0);
    check_eq("evt_o", 32'(evt), 32'd0);
    rst_i = 1'b0;

    // Register readback of both engines after each write
    for (int i = 0; i < N_RB; i++) begin
      e   = int'($urandom_range(1, 0));
      idx = reg_idx_e'(2'($urandom_range(2, 0)));
      reg_write(e, idx, 4'($urandom_range(15, 0)), $urandom);
      reg_read_check(0, idx);
      reg_read_check(1, idx);
    end

    // Each engine gets one empty job first
    for (int j = 0; j < N_JOBS; j++) begin
      if (j < `HWPE_N_ENG) begin
        run_job(j, j);
      end else begin
        run_job(int'($urandom_range(1, 0)), j);
      end
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- hwpe_subsystem.f
+incdir+common
common/hwpe_pkg.sv
hw/hwpe_cfg_demux.sv
hw/hwpe_ctrl_regs.sv
hw/copy_engine/copy_engine.sv
hw/sum_engine/sum_engine.sv
hw/hwpe_mem_mux.sv
hw/hwpe_subsystem.sv
dv/hwpe_mem_model.sv
dv/hwpe_subsystem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the HWPE subsystem testbench with Verilator, run it and check for the pass message
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f hwpe_subsystem.f \
  --top-module hwpe_subsystem_tb \
  -o sim_hwpe
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_hwpe)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TESTBENCH PASSED"; then
  exit 0
else
  echo "Pass message not found"
  exit 1
fi
